//--- verilog/dehaze_pixel_pkg.sv
// Pixel, channel and window types, channel and filter-kind enums, window constants
package dehaze_pixel_pkg;

    // ====================
    // Color values
    // ====================

    localparam int CHANNEL_W = 8;

    typedef logic [CHANNEL_W-1:0] channel_t;

    // Red in the high byte, blue in the low byte
    typedef logic [3*CHANNEL_W-1:0] pixel_t;

    // ====================
    // Window
    // ====================

    // 3x3 window in row-major order, win_0 is top left
    localparam int WINDOW_SIZE = 9;
    localparam int CENTER_IDX  = 4;

    // Channel that holds the smallest filtered value
    typedef enum logic [1:0] {
        RED   = 2'd0,
        GREEN = 2'd1,
        BLUE  = 2'd2
    } channel_e;

    // Kernel opcode chosen by the edge test
    typedef enum logic [1:0] {
        SMOOTH = 2'd0,
        EDGE   = 2'd1
    } filter_kind_e;

    // Green step that marks a window as an edge
    localparam int DEFAULT_EDGE_THRESHOLD = 32;

endpackage

//--- verilog/dehaze_fixed_pkg.sv
// Fixed-point formats, omega shift, transmission floor and reciprocal scale
package dehaze_fixed_pkg;

    // ====================
    // Inverse light
    // ====================

    // 1/A per channel in Q0.14
    localparam int INV_ATM_W = 14;

    typedef logic [INV_ATM_W-1:0] inv_atm_t;

    // omega = 1 - 2^-4 = 15/16
    localparam int OMEGA_SHIFT = 4;

    // Fraction bits dropped from Fmin * omega/A
    localparam int HAZE_FRAC_SHIFT = 14;

    // ====================
    // Transmission
    // ====================

    // Lowest transmission, 0.25 in Q0.8
    localparam int T_MIN = 64;

    // 1/t in Q3.5 is 2^13 / t when t is Q0.8
    localparam int RECIP_NUM = 8192;

    typedef logic [7:0] inv_trans_t;

    // Fraction bits of inv_trans_t
    localparam int RECIP_FRAC = 5;

endpackage

//--- verilog/window_classifier.sv
// window_classifier: green-channel edge test and stage-1 window register
`timescale 1ns/1ns
module window_classifier #(
    parameter int EDGE_THRESHOLD = dehaze_pixel_pkg::DEFAULT_EDGE_THRESHOLD
) (
    input  logic                           clk,
    input  logic                           rst,
    input  dehaze_pixel_pkg::pixel_t       win_0, win_1, win_2,
    input  dehaze_pixel_pkg::pixel_t       win_3, win_4, win_5,
    input  dehaze_pixel_pkg::pixel_t       win_6, win_7, win_8,
    output dehaze_pixel_pkg::pixel_t       reg_0, reg_1, reg_2,
    output dehaze_pixel_pkg::pixel_t       reg_3, reg_4, reg_5,
    output dehaze_pixel_pkg::pixel_t       reg_6, reg_7, reg_8,
    output dehaze_pixel_pkg::filter_kind_e kind
);

    localparam int CW = dehaze_pixel_pkg::CHANNEL_W;

    dehaze_pixel_pkg::channel_t h_diff;
    dehaze_pixel_pkg::channel_t v_diff;
    logic                       edge_found;

    // Absolute difference of the green bytes
    function automatic dehaze_pixel_pkg::channel_t green_diff(
        input dehaze_pixel_pkg::pixel_t a,
        input dehaze_pixel_pkg::pixel_t b
    );
        dehaze_pixel_pkg::channel_t ga;
        dehaze_pixel_pkg::channel_t gb;
        ga = a[CW +: CW];
        gb = b[CW +: CW];
        return (ga >= gb) ? ga - gb : gb - ga;
    endfunction

    assign h_diff     = green_diff(win_3, win_5);
    assign v_diff     = green_diff(win_1, win_7);
    assign edge_found = (h_diff >= EDGE_THRESHOLD) || (v_diff >= EDGE_THRESHOLD);

    // Stage 1
    always_ff @(posedge clk) begin
        if (rst) begin
            {reg_0, reg_1, reg_2} <= '0;
            {reg_3, reg_4, reg_5} <= '0;
            {reg_6, reg_7, reg_8} <= '0;
            kind <= dehaze_pixel_pkg::SMOOTH;
        end else begin
            {reg_0, reg_1, reg_2} <= {win_0, win_1, win_2};
            {reg_3, reg_4, reg_5} <= {win_3, win_4, win_5};
            {reg_6, reg_7, reg_8} <= {win_6, win_7, win_8};
            kind <= edge_found ? dehaze_pixel_pkg::EDGE : dehaze_pixel_pkg::SMOOTH;
        end
    end

    // The filter only decodes the two kernel opcodes
    a_kind_legal: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(kind) &&
        (kind == dehaze_pixel_pkg::SMOOTH || kind == dehaze_pixel_pkg::EDGE));

endmodule

//--- verilog/window_filter.sv
// window_filter: per-channel weighted 3x3 sum with the classified kernel, stage 2
`timescale 1ns/1ns
module window_filter (
    input  logic                           clk,
    input  logic                           rst,
    input  dehaze_pixel_pkg::pixel_t       reg_0, reg_1, reg_2,
    input  dehaze_pixel_pkg::pixel_t       reg_3, reg_4, reg_5,
    input  dehaze_pixel_pkg::pixel_t       reg_6, reg_7, reg_8,
    input  dehaze_pixel_pkg::filter_kind_e kind,
    output dehaze_pixel_pkg::channel_t     filt_r, filt_g, filt_b
);

    localparam int CW    = dehaze_pixel_pkg::CHANNEL_W;
    localparam int N     = dehaze_pixel_pkg::WINDOW_SIZE;
    localparam int SUM_W = 14;

    dehaze_pixel_pkg::pixel_t   px       [N];
    dehaze_pixel_pkg::channel_t filt_all [3];

    // Both kernels add up to 16
    function automatic logic [3:0] tap_weight(
        input dehaze_pixel_pkg::filter_kind_e k,
        input int                             idx
    );
        if (idx == dehaze_pixel_pkg::CENTER_IDX) begin
            return (k == dehaze_pixel_pkg::EDGE) ? 4'd8 : 4'd4;
        end
        // Odd indices are the four edge neighbours
        if (idx % 2 == 1) begin
            return 4'd2;
        end
        return (k == dehaze_pixel_pkg::EDGE) ? 4'd0 : 4'd1;
    endfunction

    assign px = '{reg_0, reg_1, reg_2, reg_3, reg_4, reg_5, reg_6, reg_7, reg_8};

    // Channel 0 is red, taken from the high byte
    for (genvar c = 0; c < 3; c++) begin : g_chan
        logic [SUM_W-1:0]           acc;
        dehaze_pixel_pkg::channel_t filt_q;

        always_comb begin
            acc = '0;
            for (int i = 0; i < N; i++) begin
                acc = acc + tap_weight(kind, i) * px[i][(2-c)*CW +: CW];
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                filt_q <= '0;
            end else begin
                filt_q <= CW'(acc >> 4);
            end
        end

        assign filt_all[c] = filt_q;

        // 16 x 255 must fit in 12 bits, or the shift drops a carry
        a_sum_12b: assert property (@(posedge clk) disable iff (rst)
            acc[SUM_W-1:12] == '0);
    end

    assign filt_r = filt_all[0];
    assign filt_g = filt_all[1];
    assign filt_b = filt_all[2];

endmodule

//--- verilog/sideband_pipe.sv
// sideband_pipe: delay lines for center pixel, light, scaled inverse light and valid
`timescale 1ns/1ns
module sideband_pipe (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        input_valid,
    input  dehaze_pixel_pkg::pixel_t    center,
    input  dehaze_pixel_pkg::channel_t  atm_r, atm_g, atm_b,
    input  dehaze_fixed_pkg::inv_atm_t  inv_atm_r, inv_atm_g, inv_atm_b,
    output dehaze_pixel_pkg::pixel_t    center_d2,
    output dehaze_pixel_pkg::channel_t  atm_d2_r, atm_d2_g, atm_d2_b,
    output dehaze_fixed_pkg::inv_atm_t  inv_scaled_r, inv_scaled_g, inv_scaled_b,
    output logic                        valid_d6
);

    dehaze_pixel_pkg::pixel_t   center_d1;
    logic [5:0]                 valid_sr;
    dehaze_pixel_pkg::channel_t atm_in   [3];
    dehaze_fixed_pkg::inv_atm_t inv_in   [3];
    dehaze_pixel_pkg::channel_t atm_out  [3];
    dehaze_fixed_pkg::inv_atm_t inv_out  [3];

    assign atm_in = '{atm_r, atm_g, atm_b};
    assign inv_in = '{inv_atm_r, inv_atm_g, inv_atm_b};

    always_ff @(posedge clk) begin
        if (rst) begin
            center_d1 <= '0;
            center_d2 <= '0;
            valid_sr  <= '0;
        end else begin
            center_d1 <= center;
            center_d2 <= center_d1;
            valid_sr  <= {valid_sr[4:0], input_valid};
        end
    end

    // Light and omega/A per channel, 2 cycles to meet the filter output
    for (genvar c = 0; c < 3; c++) begin : g_chan
        dehaze_pixel_pkg::channel_t atm_d1, atm_d2;
        dehaze_fixed_pkg::inv_atm_t inv_d1, inv_s2;

        always_ff @(posedge clk) begin
            if (rst) begin
                atm_d1 <= '0;
                atm_d2 <= '0;
                inv_d1 <= '0;
                inv_s2 <= '0;
            end else begin
                atm_d1 <= atm_in[c];
                atm_d2 <= atm_d1;
                inv_d1 <= inv_in[c];
                inv_s2 <= inv_d1 - (inv_d1 >> dehaze_fixed_pkg::OMEGA_SHIFT);
            end
        end

        assign atm_out[c] = atm_d2;
        assign inv_out[c] = inv_s2;
    end

    assign {atm_d2_r, atm_d2_g, atm_d2_b}             = {atm_out[0], atm_out[1], atm_out[2]};
    assign {inv_scaled_r, inv_scaled_g, inv_scaled_b} = {inv_out[0], inv_out[1], inv_out[2]};
    assign valid_d6                                   = valid_sr[5];

endmodule

//--- verilog/transmission_estimator.sv
// transmission_estimator: minimum channel, haze product and reciprocal table, stages 3-4
`timescale 1ns/1ns
module transmission_estimator (
    input  logic                         clk,
    input  logic                         rst,
    input  dehaze_pixel_pkg::channel_t   filt_r, filt_g, filt_b,
    input  dehaze_fixed_pkg::inv_atm_t   inv_scaled_r, inv_scaled_g, inv_scaled_b,
    output dehaze_fixed_pkg::inv_trans_t inv_trans
);

    localparam int CW      = dehaze_pixel_pkg::CHANNEL_W;
    localparam int PROD_W  = CW + dehaze_fixed_pkg::INV_ATM_W;
    localparam int ENTRIES = 1 << CW;

    dehaze_pixel_pkg::channel_e   min_sel;
    dehaze_pixel_pkg::channel_t   fmin;
    dehaze_fixed_pkg::inv_atm_t   inv_min;
    logic [PROD_W-1:0]            haze_full;
    logic [PROD_W-1:0]            haze_shift;
    dehaze_pixel_pkg::channel_t   haze_sat;
    dehaze_pixel_pkg::channel_t   haze_q;
    dehaze_fixed_pkg::inv_trans_t recip_table [ENTRIES];

    // One entry per haze product p, with t = 256 - p held at the floor
    function automatic dehaze_fixed_pkg::inv_trans_t recip_entry(input int p);
        int t;
        t = ENTRIES - p;
        if (t < dehaze_fixed_pkg::T_MIN) begin
            t = dehaze_fixed_pkg::T_MIN;
        end
        return dehaze_fixed_pkg::inv_trans_t'(dehaze_fixed_pkg::RECIP_NUM / t);
    endfunction

    for (genvar i = 0; i < ENTRIES; i++) begin : g_recip
        assign recip_table[i] = recip_entry(i);
    end

    // Ties go to red, then green
    always_comb begin
        if (filt_r <= filt_g && filt_r <= filt_b) begin
            min_sel = dehaze_pixel_pkg::RED;
        end else if (filt_g <= filt_b) begin
            min_sel = dehaze_pixel_pkg::GREEN;
        end else begin
            min_sel = dehaze_pixel_pkg::BLUE;
        end
    end

    always_comb begin
        case (min_sel)
            dehaze_pixel_pkg::RED: begin
                fmin    = filt_r;
                inv_min = inv_scaled_r;
            end
            dehaze_pixel_pkg::GREEN: begin
                fmin    = filt_g;
                inv_min = inv_scaled_g;
            end
            default: begin
                fmin    = filt_b;
                inv_min = inv_scaled_b;
            end
        endcase
    end

    assign haze_full  = PROD_W'(fmin) * PROD_W'(inv_min);
    assign haze_shift = haze_full >> dehaze_fixed_pkg::HAZE_FRAC_SHIFT;
    assign haze_sat   = (haze_shift[PROD_W-1:CW] != '0) ? '1 : haze_shift[CW-1:0];

    // Stage 3 holds the product, stage 4 the reciprocal
    always_ff @(posedge clk) begin
        if (rst) begin
            haze_q    <= '0;
            inv_trans <= '0;
        end else begin
            haze_q    <= haze_sat;
            inv_trans <= recip_table[haze_q];
        end
    end

    // The floor on t bounds the gain applied in scene_recovery
    a_recip_bound: assert property (@(posedge clk) disable iff (rst)
        inv_trans <= dehaze_fixed_pkg::inv_trans_t'(
            dehaze_fixed_pkg::RECIP_NUM / dehaze_fixed_pkg::T_MIN));

endmodule

//--- verilog/scene_recovery.sv
// scene_recovery: |I - A| and sign, scaling by 1/t, clamped add or subtract, stages 3-6
`timescale 1ns/1ns
module scene_recovery (
    input  logic                         clk,
    input  logic                         rst,
    input  dehaze_pixel_pkg::pixel_t     center,
    input  dehaze_pixel_pkg::channel_t   atm_r, atm_g, atm_b,
    input  dehaze_fixed_pkg::inv_trans_t inv_trans,
    output dehaze_pixel_pkg::channel_t   out_r, out_g, out_b
);

    localparam int CW     = dehaze_pixel_pkg::CHANNEL_W;
    localparam int SCALE_W = 2 * CW;

    dehaze_pixel_pkg::channel_t atm_in  [3];
    dehaze_pixel_pkg::channel_t out_all [3];

    assign atm_in = '{atm_r, atm_g, atm_b};

    for (genvar c = 0; c < 3; c++) begin : g_chan
        dehaze_pixel_pkg::channel_t i_c;
        dehaze_pixel_pkg::channel_t diff3, diff4, s5, j6;
        dehaze_pixel_pkg::channel_t a3, a4, a5;
        logic                       add3, add4, add5;
        logic [SCALE_W-1:0]         scaled;
        logic [CW:0]                sum;

        // Red in the high byte
        assign i_c = center[(2-c)*CW +: CW];

        // d * (1/t), back to an integer by dropping the Q3.5 fraction
        assign scaled = (SCALE_W'(diff4) * SCALE_W'(inv_trans)) >> dehaze_fixed_pkg::RECIP_FRAC;
        assign sum    = {1'b0, a5} + {1'b0, s5};

        always_ff @(posedge clk) begin
            if (rst) begin
                {diff3, diff4, s5, j6} <= '0;
                {a3, a4, a5}           <= '0;
                {add3, add4, add5}     <= '0;
            end else begin
                // Stage 3
                add3  <= (i_c >= atm_in[c]);
                diff3 <= (i_c >= atm_in[c]) ? i_c - atm_in[c] : atm_in[c] - i_c;
                a3    <= atm_in[c];
                // Stage 4 waits for the reciprocal
                diff4 <= diff3;
                add4  <= add3;
                a4    <= a3;
                // Stage 5
                s5    <= (scaled[SCALE_W-1:CW] != '0) ? '1 : scaled[CW-1:0];
                add5  <= add4;
                a5    <= a4;
                // Stage 6 clamps to 0..255
                if (add5) begin
                    j6 <= sum[CW] ? '1 : sum[CW-1:0];
                end else begin
                    j6 <= (a5 >= s5) ? a5 - s5 : '0;
                end
            end
        end

        assign out_all[c] = j6;
    end

    assign out_r = out_all[0];
    assign out_g = out_all[1];
    assign out_b = out_all[2];

endmodule

//--- verilog/dehaze_top.sv
// dehaze_top: six-stage dehazing pipeline from 3x3 window to recovered pixel
`timescale 1ns/1ns
module dehaze_top #(
    parameter int EDGE_THRESHOLD = dehaze_pixel_pkg::DEFAULT_EDGE_THRESHOLD
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       input_valid,
    input  dehaze_pixel_pkg::pixel_t   win_0, win_1, win_2,
    input  dehaze_pixel_pkg::pixel_t   win_3, win_4, win_5,
    input  dehaze_pixel_pkg::pixel_t   win_6, win_7, win_8,
    input  dehaze_pixel_pkg::channel_t atm_r, atm_g, atm_b,
    input  dehaze_fixed_pkg::inv_atm_t inv_atm_r, inv_atm_g, inv_atm_b,
    output dehaze_pixel_pkg::channel_t out_r, out_g, out_b,
    output logic                       output_valid
);

    // ====================
    // Stage wires
    // ====================

    dehaze_pixel_pkg::pixel_t       reg_0, reg_1, reg_2, reg_3, reg_4, reg_5;
    dehaze_pixel_pkg::pixel_t       reg_6, reg_7, reg_8;
    dehaze_pixel_pkg::filter_kind_e kind;
    dehaze_pixel_pkg::channel_t     filt_r, filt_g, filt_b;
    dehaze_pixel_pkg::pixel_t       center_d2;
    dehaze_pixel_pkg::channel_t     atm_d2_r, atm_d2_g, atm_d2_b;
    dehaze_fixed_pkg::inv_atm_t     inv_scaled_r, inv_scaled_g, inv_scaled_b;
    dehaze_fixed_pkg::inv_trans_t   inv_trans;

    window_classifier #(.EDGE_THRESHOLD(EDGE_THRESHOLD)) u_classifier (
        .clk(clk), .rst(rst),
        .win_0(win_0), .win_1(win_1), .win_2(win_2),
        .win_3(win_3), .win_4(win_4), .win_5(win_5),
        .win_6(win_6), .win_7(win_7), .win_8(win_8),
        .reg_0(reg_0), .reg_1(reg_1), .reg_2(reg_2),
        .reg_3(reg_3), .reg_4(reg_4), .reg_5(reg_5),
        .reg_6(reg_6), .reg_7(reg_7), .reg_8(reg_8),
        .kind(kind)
    );

    window_filter u_filter (
        .clk(clk), .rst(rst),
        .reg_0(reg_0), .reg_1(reg_1), .reg_2(reg_2),
        .reg_3(reg_3), .reg_4(reg_4), .reg_5(reg_5),
        .reg_6(reg_6), .reg_7(reg_7), .reg_8(reg_8),
        .kind(kind),
        .filt_r(filt_r), .filt_g(filt_g), .filt_b(filt_b)
    );

    // Center pixel is win_4
    sideband_pipe u_sideband (
        .clk(clk), .rst(rst), .input_valid(input_valid), .center(win_4),
        .atm_r(atm_r), .atm_g(atm_g), .atm_b(atm_b),
        .inv_atm_r(inv_atm_r), .inv_atm_g(inv_atm_g), .inv_atm_b(inv_atm_b),
        .center_d2(center_d2),
        .atm_d2_r(atm_d2_r), .atm_d2_g(atm_d2_g), .atm_d2_b(atm_d2_b),
        .inv_scaled_r(inv_scaled_r), .inv_scaled_g(inv_scaled_g),
        .inv_scaled_b(inv_scaled_b),
        .valid_d6(output_valid)
    );

    transmission_estimator u_trans (
        .clk(clk), .rst(rst),
        .filt_r(filt_r), .filt_g(filt_g), .filt_b(filt_b),
        .inv_scaled_r(inv_scaled_r), .inv_scaled_g(inv_scaled_g),
        .inv_scaled_b(inv_scaled_b),
        .inv_trans(inv_trans)
    );

    scene_recovery u_recovery (
        .clk(clk), .rst(rst), .center(center_d2),
        .atm_r(atm_d2_r), .atm_g(atm_d2_g), .atm_b(atm_d2_b),
        .inv_trans(inv_trans),
        .out_r(out_r), .out_g(out_g), .out_b(out_b)
    );

endmodule

//--- dv/dehaze_checker.sv
// dehaze_checker: reference model, expected-result queue, output comparison and counts
`timescale 1ns/1ns
module dehaze_checker #(
    parameter int EDGE_THRESHOLD = dehaze_pixel_pkg::DEFAULT_EDGE_THRESHOLD,
    parameter int LATENCY        = 6
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       input_valid,
    input  dehaze_pixel_pkg::pixel_t   win_0, win_1, win_2,
    input  dehaze_pixel_pkg::pixel_t   win_3, win_4, win_5,
    input  dehaze_pixel_pkg::pixel_t   win_6, win_7, win_8,
    input  dehaze_pixel_pkg::channel_t atm_r, atm_g, atm_b,
    input  dehaze_fixed_pkg::inv_atm_t inv_atm_r, inv_atm_g, inv_atm_b,
    input  dehaze_pixel_pkg::channel_t out_r, out_g, out_b,
    input  logic                       output_valid,
    input  int                         test_id,
    input  logic                       end_test,
    input  logic                       end_run,
    output int                         error_count,
    output int                         pending
);

    // Kernel weights in row-major order, both sum to 16
    localparam int SMOOTH_W [9] = '{1, 2, 1, 2, 4, 2, 1, 2, 1};
    localparam int EDGE_W   [9] = '{0, 2, 0, 2, 8, 2, 0, 2, 0};

    logic [23:0]              exp_q [$];
    int                       id_q  [$];
    int                       cyc_q [$];
    dehaze_pixel_pkg::pixel_t win   [9];
    int                       atm   [3];
    int                       inv   [3];
    logic [23:0]              exp_px;
    int                       exp_id;
    int                       exp_cyc;
    int                       cycle        = 0;
    int                       test_checks  = 0;
    int                       test_errors  = 0;
    int                       total_checks = 0;

    initial begin
        error_count = 0;
        pending     = 0;
    end

    function automatic string test_name(input int id);
        case (id)
            0:       return "flat";
            1:       return "random";
            2:       return "edge";
            3:       return "center";
            4:       return "gaps";
            default: return "unknown";
        endcase
    endfunction

    // Channel 0 is red in the high byte
    function automatic int byte_of(input dehaze_pixel_pkg::pixel_t p, input int c);
        return int'((p >> (8 * (2 - c))) & 24'hff);
    endfunction

    // ====================
    // Reference model
    // ====================

    function automatic logic [23:0] recover_pixel(
        input dehaze_pixel_pkg::pixel_t w   [9],
        input int                       a   [3],
        input int                       iv  [3]
    );
        int          gh, gv, sum, m, p, t, recip, ic, d, s, j;
        int          f     [3];
        int          inv_s [3];
        logic        is_edge;
        logic [23:0] res;
        gh = byte_of(w[3], 1) - byte_of(w[5], 1);
        gv = byte_of(w[1], 1) - byte_of(w[7], 1);
        if (gh < 0) gh = -gh;
        if (gv < 0) gv = -gv;
        is_edge = (gh >= EDGE_THRESHOLD) || (gv >= EDGE_THRESHOLD);
        for (int c = 0; c < 3; c++) begin
            sum = 0;
            for (int i = 0; i < 9; i++) begin
                sum += (is_edge ? EDGE_W[i] : SMOOTH_W[i]) * byte_of(w[i], c);
            end
            f[c]     = sum / 16;
            inv_s[c] = iv[c] - iv[c] / 16;
        end
        // Ties keep the earlier channel
        m = 0;
        if (f[1] < f[0]) m = 1;
        if (f[2] < f[m]) m = 2;
        p = (f[m] * inv_s[m]) / 16384;
        if (p > 255) p = 255;
        t = 256 - p;
        if (t < 64) t = 64;
        recip = 8192 / t;
        for (int c = 0; c < 3; c++) begin
            ic = byte_of(w[4], c);
            d  = (ic >= a[c]) ? ic - a[c] : a[c] - ic;
            s  = (d * recip) / 32;
            if (s > 255) s = 255;
            j  = (ic >= a[c]) ? a[c] + s : a[c] - s;
            if (j > 255) j = 255;
            if (j < 0) j = 0;
            res[8 * (2 - c) +: 8] = 8'(j);
        end
        return res;
    endfunction

    task automatic compare_channel(input int id, input string chan, input int e, input int act);
        if (e != act) begin
            $display("error: test %s, %s expected %0d, actual %0d", test_name(id), chan, e, act);
            test_errors++;
            error_count++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("Test %s: %s", test_name(test_id), msg);
        test_errors++;
        error_count++;
    endtask

    // ====================
    // Sampling and comparison
    // ====================

    // Everything is sampled on the falling edge, half a cycle before the DUT
    // registers the inputs, so an output shows up LATENCY samples later
    always @(negedge clk) begin
        if (!rst) begin
            cycle++;
            if (output_valid) begin
                if (exp_q.size() == 0) begin
                    report_failure("output_valid pulsed with no window in flight");
                end else begin
                    exp_px  = exp_q.pop_front();
                    exp_id  = id_q.pop_front();
                    exp_cyc = cyc_q.pop_front();
                    if (cycle - exp_cyc != LATENCY) begin
                        report_failure($sformatf("output came %0d cycles after its window",
                                                 cycle - exp_cyc));
                    end
                    compare_channel(exp_id, "out_r", int'(exp_px[23:16]), int'(out_r));
                    compare_channel(exp_id, "out_g", int'(exp_px[15:8]), int'(out_g));
                    compare_channel(exp_id, "out_b", int'(exp_px[7:0]), int'(out_b));
                    test_checks++;
                    total_checks++;
                end
            end else if (exp_q.size() != 0 && cycle - cyc_q[0] >= LATENCY) begin
                report_failure("output_valid missing for a window that was sent");
                void'(exp_q.pop_front());
                void'(id_q.pop_front());
                void'(cyc_q.pop_front());
            end
            if (input_valid) begin
                win = '{win_0, win_1, win_2, win_3, win_4, win_5, win_6, win_7, win_8};
                atm = '{int'(atm_r), int'(atm_g), int'(atm_b)};
                inv = '{int'(inv_atm_r), int'(inv_atm_g), int'(inv_atm_b)};
                exp_q.push_back(recover_pixel(win, atm, inv));
                id_q.push_back(test_id);
                cyc_q.push_back(cycle);
            end
            if (end_test) begin
                if (test_checks == 0) begin
                    report_failure("no outputs were checked");
                end
                $display("Test %s: %0d windows checked, %0d errors",
                         test_name(test_id), test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
            if (end_run) begin
                $display("Total: %0d windows checked, %0d errors", total_checks, error_count);
            end
        end
        pending = exp_q.size();
    end

endmodule

//--- dv/dehaze_tb.sv
// dehaze_tb: clock, reset, seeded random stimulus per test, timeout, DUT and checker
`timescale 1ns/1ns
module dehaze_tb;

    localparam int EDGE_THRESHOLD = dehaze_pixel_pkg::DEFAULT_EDGE_THRESHOLD;
    localparam int LATENCY        = 6;
    localparam int RESET_CYCLES   = 16;

    // Test ids, matched by the checker's names
    localparam int T_FLAT   = 0;
    localparam int T_RANDOM = 1;
    localparam int T_EDGE   = 2;
    localparam int T_CENTER = 3;
    localparam int T_GAPS   = 4;

    localparam int N_FLAT   = 50;
    localparam int N_RANDOM = 400;
    localparam int N_EDGE   = 150;
    localparam int N_CENTER = 50;
    localparam int N_GAPS   = 300;

    // Gaps test sends on about 5 of 8 cycles, budgeted at 2 cycles per window
    localparam int TEST_OVERHEAD = 2 * LATENCY + 8;
    localparam int MAX_CYCLES    = RESET_CYCLES + N_FLAT + N_RANDOM + N_EDGE + N_CENTER
                                   + 2 * N_GAPS + 5 * TEST_OVERHEAD + 200;

    logic                       clk;
    logic                       rst;
    logic                       input_valid;
    dehaze_pixel_pkg::pixel_t   win [9];
    dehaze_pixel_pkg::channel_t atm [3];
    dehaze_fixed_pkg::inv_atm_t inv [3];
    dehaze_pixel_pkg::channel_t out_r, out_g, out_b;
    logic                       output_valid;
    int                         test_id;
    logic                       end_test;
    logic                       end_run;
    int                         error_count;
    int                         pending;
    integer                     seed;
    int                         cycle = 0;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    dehaze_top #(.EDGE_THRESHOLD(EDGE_THRESHOLD)) u_dut (
        .clk(clk), .rst(rst), .input_valid(input_valid),
        .win_0(win[0]), .win_1(win[1]), .win_2(win[2]),
        .win_3(win[3]), .win_4(win[4]), .win_5(win[5]),
        .win_6(win[6]), .win_7(win[7]), .win_8(win[8]),
        .atm_r(atm[0]), .atm_g(atm[1]), .atm_b(atm[2]),
        .inv_atm_r(inv[0]), .inv_atm_g(inv[1]), .inv_atm_b(inv[2]),
        .out_r(out_r), .out_g(out_g), .out_b(out_b),
        .output_valid(output_valid)
    );

    dehaze_checker #(.EDGE_THRESHOLD(EDGE_THRESHOLD), .LATENCY(LATENCY)) u_checker (
        .clk(clk), .rst(rst), .input_valid(input_valid),
        .win_0(win[0]), .win_1(win[1]), .win_2(win[2]),
        .win_3(win[3]), .win_4(win[4]), .win_5(win[5]),
        .win_6(win[6]), .win_7(win[7]), .win_8(win[8]),
        .atm_r(atm[0]), .atm_g(atm[1]), .atm_b(atm[2]),
        .inv_atm_r(inv[0]), .inv_atm_g(inv[1]), .inv_atm_b(inv[2]),
        .out_r(out_r), .out_g(out_g), .out_b(out_b),
        .output_valid(output_valid),
        .test_id(test_id), .end_test(end_test), .end_run(end_run),
        .error_count(error_count), .pending(pending)
    );

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // Q0.14 inverse of the light, capped at the largest code
    function automatic dehaze_fixed_pkg::inv_atm_t inverse_of(input dehaze_pixel_pkg::channel_t a);
        int q;
        q = (a == 0) ? 16383 : 16384 / int'(a);
        if (q > 16383) q = 16383;
        return dehaze_fixed_pkg::inv_atm_t'(q);
    endfunction

    // Bright light in 128..255 with its matching inverse
    task automatic set_typical_light();
        for (int c = 0; c < 3; c++) begin
            atm[c] = 8'h80 | dehaze_pixel_pkg::channel_t'(next_rand());
            inv[c] = inverse_of(atm[c]);
        end
    endtask

    // ====================
    // Window generators
    // ====================

    task automatic fill_window(input int id);
        dehaze_pixel_pkg::pixel_t p;
        int                       lo, hi, a_idx, b_idx;
        logic [31:0]              r;
        p = dehaze_pixel_pkg::pixel_t'(next_rand());
        for (int i = 0; i < 9; i++) begin
            win[i] = (id == T_FLAT) ? p : dehaze_pixel_pkg::pixel_t'(next_rand());
        end
        if (id == T_RANDOM || id == T_GAPS) begin
            for (int c = 0; c < 3; c++) begin
                atm[c] = dehaze_pixel_pkg::channel_t'(next_rand());
                inv[c] = dehaze_fixed_pkg::inv_atm_t'(next_rand());
            end
        end else begin
            set_typical_light();
        end
        if (id == T_EDGE) begin
            // Green step across the row or the column, either direction
            r     = next_rand();
            lo    = int'(r[15:8]) % (256 - EDGE_THRESHOLD);
            hi    = lo + EDGE_THRESHOLD + int'(r[31:16]) % (256 - EDGE_THRESHOLD - lo);
            a_idx = r[0] ? 3 : 1;
            b_idx = r[0] ? 5 : 7;
            win[r[1] ? a_idx : b_idx][15:8] = 8'(lo);
            win[r[1] ? b_idx : a_idx][15:8] = 8'(hi);
        end
        if (id == T_CENTER) begin
            atm[0] = win[4][23:16];
            atm[1] = win[4][15:8];
            atm[2] = win[4][7:0];
            for (int c = 0; c < 3; c++) begin
                inv[c] = inverse_of(atm[c]);
            end
        end
    endtask

    task automatic run_test(input int id, input int count);
        int          sent;
        logic [31:0] r;
        sent    = 0;
        test_id = id;
        while (sent < count) begin
            @(posedge clk);
            #1;
            r           = next_rand();
            input_valid = (id != T_GAPS) || (r[2:0] > 3'd2);
            fill_window(id);
            if (input_valid) sent++;
        end
        @(posedge clk);
        #1 input_valid = 1'b0;
        while (pending != 0) @(posedge clk);
        // Room for a stray output_valid to show up
        repeat (LATENCY + 1) @(posedge clk);
        #1 end_test = 1'b1;
        @(posedge clk);
        #1 end_test = 1'b0;
    endtask

    initial begin
        seed        = 32'hbcd973f6;
        rst         = 1'b1;
        input_valid = 1'b0;
        test_id     = T_FLAT;
        end_test    = 1'b0;
        end_run     = 1'b0;
        for (int i = 0; i < 9; i++) win[i] = '0;
        for (int c = 0; c < 3; c++) begin
            atm[c] = '0;
            inv[c] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        run_test(T_FLAT, N_FLAT);
        run_test(T_RANDOM, N_RANDOM);
        run_test(T_EDGE, N_EDGE);
        run_test(T_CENTER, N_CENTER);
        run_test(T_GAPS, N_GAPS);
        #1 end_run = 1'b1;
        @(posedge clk);
        #1 end_run = 1'b0;
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Cycle limit from the test lengths above
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d windows in flight", cycle, pending);
            $display("ERRORS FOUND");
            $finish;
        end
    end

endmodule

//--- dehaze_top.f
verilog/dehaze_pixel_pkg.sv
verilog/dehaze_fixed_pkg.sv
verilog/window_classifier.sv
verilog/window_filter.sv
verilog/sideband_pipe.sv
verilog/transmission_estimator.sv
verilog/scene_recovery.sv
verilog/dehaze_top.sv
dv/dehaze_checker.sv
dv/dehaze_tb.sv

//--- Makefile
# Verilator simulation of the dehazing pipeline

VERILATOR ?= verilator
TOP       ?= dehaze_tb
FILELIST  ?= dehaze_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= NO ERRORS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
